/* hw/rvx_consts.svh */
`ifndef RVX_CONSTS_SVH
`define RVX_CONSTS_SVH

// Width of one data word and one instruction word
`define RVX_XLEN 32

// Architectural registers, index 0 hardwired to zero
`define RVX_NREG 32

// Instruction FIFO entries
`define RVX_FIFO_DEPTH 8

// Scratch data memory words, addressed by the low bits of rs1 plus imm
`define RVX_DMEM_WORDS 16

// APB map. Instruction push is write-only
`define RVX_ADDR_INSTR 12'h000
// Status word holds busy in bit 0 and the FIFO count in bits 7:4
`define RVX_ADDR_STATUS 12'h004
// Register r is read at this base plus four times r
`define RVX_ADDR_REG_BASE 12'h080

`endif

/* hw/rvx_pkg.sv */
`include "rvx_consts.svh"

// Instruction format, one 32-bit word
//   op   bits 31:28
//   rd   bits 27:23
//   rs1  bits 22:18
//   rs2  bits 17:13
//   imm  bits 12:0, sign-extended to the word width
// Opcode values 8 to 15 are not defined and execute as NOP
package rvx_pkg;

    typedef logic [`RVX_XLEN-1:0] word_t;

    // Index 0 always reads zero and ignores writes
    typedef logic [$clog2(`RVX_NREG)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LW   = 4'h6,
        OP_SW   = 4'h7
    } opcode_t;

    // Where a stage's register result comes from
    typedef enum logic [1:0] {
        RES_NONE = 2'd0,
        RES_ALU  = 2'd1,
        RES_MEM  = 2'd2
    } res_src_t;

endpackage

/* hw/rvx_apb_cmd.sv */
`timescale 1ns/1ps
`include "rvx_consts.svh"

module rvx_apb_cmd (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [11:0]        paddr,
    input  rvx_pkg::word_t     pwdata,
    output rvx_pkg::word_t     prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               push,
    output rvx_pkg::word_t     push_data,
    input  logic               full,
    input  logic [3:0]         count,
    input  logic               empty,
    input  logic               busy,
    output rvx_pkg::reg_idx_t  dbg_idx,
    input  rvx_pkg::word_t     dbg_data
);

    logic           is_instr;
    logic           is_status;
    logic           is_reg;
    logic           setup;
    logic           done;
    logic           err_d;
    logic           busy_bit;
    rvx_pkg::word_t rd_word;

    // Register window covers 0x080 to 0x0fc on word boundaries
    assign is_instr  = (paddr == `RVX_ADDR_INSTR);
    assign is_status = (paddr == `RVX_ADDR_STATUS);
    assign is_reg    = ((paddr & 12'hf83) == `RVX_ADDR_REG_BASE);

    // Work is still pending while the FIFO holds words or any stage is valid
    assign busy_bit = busy | ~empty;

    // Register index comes straight from the word offset in the window
    assign dbg_idx = paddr[6:2];

    // An instruction push waits in the access phase while the FIFO is full
    assign pready = psel & penable & ~(pwrite & is_instr & full);
    assign setup  = psel & ~penable;
    assign done   = psel & penable & pready;

    // Only a clean completion to the push address reaches the FIFO
    assign push      = done & pwrite & is_instr;
    assign push_data = pwdata;

    // Writes are legal only at the push address, reads only at status or registers
    assign err_d = pwrite ? ~is_instr : ~(is_status | is_reg);

    always_comb begin
        rd_word = '0;
        if (is_status) begin
            rd_word = {{(`RVX_XLEN-8){1'b0}}, count, 3'b000, busy_bit};
        end else if (is_reg) begin
            rd_word = dbg_data;
        end
    end

    // Response is captured in the setup cycle so reads finish in the first access cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pslverr <= 1'b0;
        end else if (setup) begin
            pslverr <= err_d;
        end else if (done) begin
            pslverr <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (setup && !pwrite) begin
            prdata <= rd_word;
        end
    end

endmodule

/* hw/rvx_instr_fifo.sv */
`timescale 1ns/1ps
`include "rvx_consts.svh"

module rvx_instr_fifo (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  rvx_pkg::word_t push_data,
    input  logic           pop,
    output rvx_pkg::word_t pop_data,
    output logic           full,
    output logic           empty,
    output logic [3:0]     count
);

    localparam int AW = $clog2(`RVX_FIFO_DEPTH);

    rvx_pkg::word_t mem [`RVX_FIFO_DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic           do_push;
    logic           do_pop;

    // Depth is a power of two so the pointers wrap on their own
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign full     = (count == 4'(`RVX_FIFO_DEPTH));
    assign empty    = (count == 4'd0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 4'd0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // A push and pop in the same cycle leave the count as it is
            case ({do_push, do_pop})
                2'b10:   count <= count + 4'd1;
                2'b01:   count <= count - 4'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* hw/rvx_regfile.sv */
`timescale 1ns/1ps
`include "rvx_consts.svh"

module rvx_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rvx_pkg::reg_idx_t rs1,
    input  rvx_pkg::reg_idx_t rs2,
    input  rvx_pkg::reg_idx_t dbg_idx,
    output rvx_pkg::word_t    rs1_data,
    output rvx_pkg::word_t    rs2_data,
    output rvx_pkg::word_t    dbg_data,
    input  logic              we,
    input  rvx_pkg::reg_idx_t rd,
    input  rvx_pkg::word_t    rd_data
);

    rvx_pkg::word_t regs [`RVX_NREG];

    // Write-first read, so an ID read sees the value WB writes in the same cycle
    function automatic rvx_pkg::word_t read_port(input rvx_pkg::reg_idx_t idx);
        rvx_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (we && rd == idx) begin
            val = rd_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
        dbg_data = read_port(dbg_idx);
    end

    // Register 0 is never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RVX_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

/* hw/rvx_forward.sv */
`timescale 1ns/1ps

module rvx_forward (
    input  rvx_pkg::reg_idx_t rs1_ex,
    input  rvx_pkg::reg_idx_t rs2_ex,
    input  rvx_pkg::word_t    rs1_data_ex,
    input  rvx_pkg::word_t    rs2_data_ex,
    input  rvx_pkg::reg_idx_t rd_mem,
    input  logic              reg_write_mem,
    input  rvx_pkg::res_src_t res_src_mem,
    input  rvx_pkg::word_t    result_mem,
    input  rvx_pkg::reg_idx_t rd_wb,
    input  logic              reg_write_wb,
    input  rvx_pkg::word_t    rd_data_wb,
    output rvx_pkg::word_t    fwd_rs1_ex,
    output rvx_pkg::word_t    fwd_rs2_ex
);

    logic mem_ok;
    logic wb_ok;
    logic mem_fwd_a;
    logic mem_fwd_b;
    logic wb_fwd_a;
    logic wb_fwd_b;

    // A load in MEM has only issued its read, its data shows up in WB
    assign mem_ok = reg_write_mem && rd_mem != '0 && res_src_mem != rvx_pkg::RES_MEM;

    // Writes to register 0 are dropped, so they are never forwarded either
    assign wb_ok = reg_write_wb && rd_wb != '0;

    assign mem_fwd_a = mem_ok && (rd_mem == rs1_ex);
    assign mem_fwd_b = mem_ok && (rd_mem == rs2_ex);
    assign wb_fwd_a  = wb_ok && (rd_wb == rs1_ex);
    assign wb_fwd_b  = wb_ok && (rd_wb == rs2_ex);

    // MEM is the younger producer so it wins over WB
    always_comb begin
        case (1'b1)
            mem_fwd_a: fwd_rs1_ex = result_mem;
            wb_fwd_a:  fwd_rs1_ex = rd_data_wb;
            default:   fwd_rs1_ex = rs1_data_ex;
        endcase
    end

    always_comb begin
        case (1'b1)
            mem_fwd_b: fwd_rs2_ex = result_mem;
            wb_fwd_b:  fwd_rs2_ex = rd_data_wb;
            default:   fwd_rs2_ex = rs2_data_ex;
        endcase
    end

endmodule

/* hw/rvx_core.sv */
`timescale 1ns/1ps
`include "rvx_consts.svh"

module rvx_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              empty,
    input  rvx_pkg::word_t    pop_data,
    output logic              pop,
    output logic              busy,
    input  rvx_pkg::reg_idx_t dbg_idx,
    output rvx_pkg::word_t    dbg_data
);

    localparam int MW = $clog2(`RVX_DMEM_WORDS);

    logic                    id_valid;
    rvx_pkg::word_t          id_instr;
    rvx_pkg::opcode_t        id_op;
    rvx_pkg::reg_idx_t       id_rd, id_rs1, id_rs2;
    rvx_pkg::word_t          id_imm, id_rs1_data, id_rs2_data;
    logic                    id_use_rs1, id_use_rs2, id_store;
    rvx_pkg::res_src_t       id_res_src;
    logic                    stall;

    logic                    ex_valid, ex_reg_write, ex_store;
    rvx_pkg::res_src_t       ex_res_src;
    rvx_pkg::opcode_t        ex_op;
    rvx_pkg::reg_idx_t       ex_rd, ex_rs1, ex_rs2;
    rvx_pkg::word_t          ex_imm, ex_rs1_data, ex_rs2_data;
    rvx_pkg::word_t          ex_a, ex_b, ex_result;

    logic                    mem_valid, mem_reg_write, mem_store;
    rvx_pkg::res_src_t       mem_res_src;
    rvx_pkg::reg_idx_t       mem_rd;
    rvx_pkg::word_t          mem_result, mem_store_data;
    logic [MW-1:0]           mem_idx;
    rvx_pkg::word_t          dmem [`RVX_DMEM_WORDS];

    logic                    wb_valid, wb_reg_write;
    rvx_pkg::res_src_t       wb_res_src;
    rvx_pkg::reg_idx_t       wb_rd;
    rvx_pkg::word_t          wb_result, wb_load_data, wb_data;

    // A popped word lands in ID on the next edge
    assign pop  = ~empty & ~stall;
    assign busy = id_valid | ex_valid | mem_valid | wb_valid;

    assign id_op  = rvx_pkg::opcode_t'(id_instr[31:28]);
    assign id_rd  = id_instr[27:23];
    assign id_rs1 = id_instr[22:18];
    assign id_rs2 = id_instr[17:13];
    assign id_imm = {{(`RVX_XLEN-13){id_instr[12]}}, id_instr[12:0]};

    // Decode which source registers matter and where the result comes from
    always_comb begin
        id_use_rs1 = 1'b0;
        id_use_rs2 = 1'b0;
        id_store   = 1'b0;
        id_res_src = rvx_pkg::RES_NONE;
        case (id_op)
            rvx_pkg::OP_ADD, rvx_pkg::OP_SUB, rvx_pkg::OP_AND, rvx_pkg::OP_XOR: begin
                id_use_rs1 = 1'b1;
                id_use_rs2 = 1'b1;
                id_res_src = rvx_pkg::RES_ALU;
            end
            rvx_pkg::OP_ADDI: begin
                id_use_rs1 = 1'b1;
                id_res_src = rvx_pkg::RES_ALU;
            end
            rvx_pkg::OP_LW: begin
                id_use_rs1 = 1'b1;
                id_res_src = rvx_pkg::RES_MEM;
            end
            // Store reads rs1 for the index and rs2 for the data
            rvx_pkg::OP_SW: begin
                id_use_rs1 = 1'b1;
                id_use_rs2 = 1'b1;
                id_store   = 1'b1;
            end
            default: ;
        endcase
    end

    // Load in EX feeding ID. One bubble lets the load reach WB before the consumer hits EX
    assign stall = id_valid && ex_res_src == rvx_pkg::RES_MEM && ex_rd != '0 &&
                   ((id_use_rs1 && id_rs1 == ex_rd) || (id_use_rs2 && id_rs2 == ex_rd));

    rvx_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .dbg_idx  (dbg_idx),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data),
        .dbg_data (dbg_data),
        .we       (wb_reg_write),
        .rd       (wb_rd),
        .rd_data  (wb_data)
    );

    rvx_forward u_forward (
        .rs1_ex        (ex_rs1),
        .rs2_ex        (ex_rs2),
        .rs1_data_ex   (ex_rs1_data),
        .rs2_data_ex   (ex_rs2_data),
        .rd_mem        (mem_rd),
        .reg_write_mem (mem_reg_write),
        .res_src_mem   (mem_res_src),
        .result_mem    (mem_result),
        .rd_wb         (wb_rd),
        .reg_write_wb  (wb_reg_write),
        .rd_data_wb    (wb_data),
        .fwd_rs1_ex    (ex_a),
        .fwd_rs2_ex    (ex_b)
    );

    // Loads, stores and NOP all use the rs1 plus imm sum
    always_comb begin
        case (ex_op)
            rvx_pkg::OP_ADD: ex_result = ex_a + ex_b;
            rvx_pkg::OP_SUB: ex_result = ex_a - ex_b;
            rvx_pkg::OP_AND: ex_result = ex_a & ex_b;
            rvx_pkg::OP_XOR: ex_result = ex_a ^ ex_b;
            default:         ex_result = ex_a + ex_imm;
        endcase
    end

    assign mem_idx = mem_result[MW-1:0];
    assign wb_data = (wb_res_src == rvx_pkg::RES_MEM) ? wb_load_data : wb_result;

    // Stage valid and control bits. A stall holds ID and sends a bubble into EX
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid      <= 1'b0;
            ex_valid      <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_store      <= 1'b0;
            ex_res_src    <= rvx_pkg::RES_NONE;
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_store     <= 1'b0;
            mem_res_src   <= rvx_pkg::RES_NONE;
            wb_valid      <= 1'b0;
            wb_reg_write  <= 1'b0;
            wb_res_src    <= rvx_pkg::RES_NONE;
        end else begin
            if (!stall) begin
                id_valid <= pop;
            end
            ex_valid      <= id_valid & ~stall;
            ex_reg_write  <= id_valid & ~stall & (id_res_src != rvx_pkg::RES_NONE);
            ex_store      <= id_valid & ~stall & id_store;
            ex_res_src    <= (id_valid && !stall) ? id_res_src : rvx_pkg::RES_NONE;
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_reg_write;
            mem_store     <= ex_store;
            mem_res_src   <= ex_res_src;
            wb_valid      <= mem_valid;
            wb_reg_write  <= mem_reg_write;
            wb_res_src    <= mem_res_src;
        end
    end

    // Payload registers along the pipe
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_instr <= pop_data;
        end
        ex_op          <= id_op;
        ex_rd          <= id_rd;
        ex_rs1         <= id_rs1;
        ex_rs2         <= id_rs2;
        ex_imm         <= id_imm;
        ex_rs1_data    <= id_rs1_data;
        ex_rs2_data    <= id_rs2_data;
        mem_rd         <= ex_rd;
        mem_result     <= ex_result;
        mem_store_data <= ex_b;
        wb_rd          <= mem_rd;
        wb_result      <= mem_result;
        // Synchronous read issued in MEM, data valid in WB
        wb_load_data   <= dmem[mem_idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RVX_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_store) begin
            dmem[mem_idx] <= mem_store_data;
        end
    end

endmodule

/* hw/rvx_top.sv */
`timescale 1ns/1ps

module rvx_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [11:0]    paddr,
    input  rvx_pkg::word_t pwdata,
    output rvx_pkg::word_t prdata,
    output logic           pready,
    output logic           pslverr
);

    logic              push;
    logic              pop;
    logic              full;
    logic              empty;
    logic              busy;
    logic [3:0]        count;
    rvx_pkg::word_t    push_data;
    rvx_pkg::word_t    pop_data;
    rvx_pkg::word_t    dbg_data;
    rvx_pkg::reg_idx_t dbg_idx;

    // APB slave feeds the FIFO and reads registers through the core's debug port
    rvx_apb_cmd u_apb_cmd (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .count     (count),
        .empty     (empty),
        .busy      (busy),
        .dbg_idx   (dbg_idx),
        .dbg_data  (dbg_data)
    );

    rvx_instr_fifo u_instr_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty),
        .count     (count)
    );

    // Core drains the FIFO one word per cycle unless a load-use stall holds it
    rvx_core u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty    (empty),
        .pop_data (pop_data),
        .pop      (pop),
        .busy     (busy),
        .dbg_idx  (dbg_idx),
        .dbg_data (dbg_data)
    );

endmodule

/* dv/rvx_tb_assert.sv */
`timescale 1ns/1ps

module rvx_tb_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              pop,
    input logic              stall,
    input rvx_pkg::word_t    id_instr,
    input logic              ex_valid,
    input rvx_pkg::reg_idx_t ex_rs1,
    input rvx_pkg::reg_idx_t ex_rs2,
    input rvx_pkg::word_t    ex_rs1_data,
    input rvx_pkg::word_t    ex_rs2_data,
    input rvx_pkg::word_t    ex_a,
    input rvx_pkg::word_t    ex_b,
    input rvx_pkg::res_src_t mem_res_src,
    input rvx_pkg::reg_idx_t mem_rd,
    input logic              wb_reg_write,
    input rvx_pkg::reg_idx_t wb_rd
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // A load in MEM has no data yet, so an EX operand naming its rd keeps the
    // register-file value unless WB writes that same register
    a_no_load_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_res_src == rvx_pkg::RES_MEM && !$isunknown({ex_rs1, ex_rs2})) |->
        (mem_rd != ex_rs1 || (wb_reg_write && wb_rd == ex_rs1) || ex_a == ex_rs1_data) &&
        (mem_rd != ex_rs2 || (wb_reg_write && wb_rd == ex_rs2) || ex_b == ex_rs2_data))
    else begin
        fail_count++;
        $error("MEM data forwarded while a load is in MEM");
    end

    // One bubble always resolves a load-use hazard
    a_stall_once: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall)
    else begin
        fail_count++;
        $error("load-use stall held for two cycles");
    end

    // Register 0 reaches the ALU as zero, whatever is in MEM or WB
    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid |-> (ex_rs1 != '0 || ex_a == '0) && (ex_rs2 != '0 || ex_b == '0))
    else begin
        fail_count++;
        $error("register 0 read a nonzero value");
    end

    // A pop only takes a pushed word, so ID never loads an unwritten slot
    a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |=> !$isunknown(id_instr))
    else begin
        fail_count++;
        $error("pop took a word that was never pushed");
    end

endmodule

bind rvx_core rvx_tb_assert u_tb_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop          (pop),
    .stall        (stall),
    .id_instr     (id_instr),
    .ex_valid     (ex_valid),
    .ex_rs1       (ex_rs1),
    .ex_rs2       (ex_rs2),
    .ex_rs1_data  (ex_rs1_data),
    .ex_rs2_data  (ex_rs2_data),
    .ex_a         (ex_a),
    .ex_b         (ex_b),
    .mem_res_src  (mem_res_src),
    .mem_rd       (mem_rd),
    .wb_reg_write (wb_reg_write),
    .wb_rd        (wb_rd)
);

/* dv/rvx_tb.sv */
`timescale 1ns/1ps
`include "rvx_consts.svh"

module rvx_tb;

    localparam int CLK_PERIOD = 40;
    localparam int N_ALU      = 60;
    localparam int N_LDUSE    = 30;
    localparam int N_BURST    = 20;
    localparam int N_R0       = 8;
    // Each load-use group issues a store, a load and one consumer
    localparam int N_INSTR    = N_ALU + 3 * N_LDUSE + N_BURST + N_R0;
    localparam int WDOG_CYC   = 200 * N_INSTR + 2000;

    logic           clk;
    logic           rst_n;
    logic           psel;
    logic           penable;
    logic           pwrite;
    logic [11:0]    paddr;
    rvx_pkg::word_t pwdata;
    rvx_pkg::word_t prdata;
    logic           pready;
    logic           pslverr;

    logic [31:0]    lfsr_state;
    // Architectural state, updated in program order as words are issued
    rvx_pkg::word_t model_regs [`RVX_NREG];
    rvx_pkg::word_t model_mem [`RVX_DMEM_WORDS];

    rvx_top u_rvx_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_word(input string name, input rvx_pkg::word_t got,
                              input rvx_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input logic [3:0] got,
                               input logic [3:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1, one shift per bit handed out
    function automatic logic next_rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_rand_bit()};
        end
        return v;
    endfunction

    // Small pool r0 to r7 so that back-to-back words often share registers
    function automatic rvx_pkg::reg_idx_t pool_reg();
        return rvx_pkg::reg_idx_t'(rand_bits(3));
    endfunction

    // ADD, SUB, AND, XOR and ADDI sit at encodings 1 to 5
    function automatic rvx_pkg::opcode_t alu_op();
        return rvx_pkg::opcode_t'(4'(rand_bits(3) % 5 + 1));
    endfunction

    function automatic rvx_pkg::word_t make_instr(input rvx_pkg::opcode_t op,
                                                  input rvx_pkg::reg_idx_t rd,
                                                  input rvx_pkg::reg_idx_t rs1,
                                                  input rvx_pkg::reg_idx_t rs2,
                                                  input logic [12:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    task automatic model_exec(input rvx_pkg::word_t ins);
        rvx_pkg::reg_idx_t rd;
        rvx_pkg::word_t    a;
        rvx_pkg::word_t    b;
        rvx_pkg::word_t    imm;
        rvx_pkg::word_t    res;
        int                midx;
        logic              wr;
        rd   = ins[27:23];
        a    = model_regs[ins[22:18]];
        b    = model_regs[ins[17:13]];
        imm  = {{(`RVX_XLEN-13){ins[12]}}, ins[12:0]};
        // Scratch index is the low bits of rs1 plus imm
        midx = int'((a + imm) % `RVX_DMEM_WORDS);
        wr   = 1'b1;
        res  = '0;
        case (ins[31:28])
            rvx_pkg::OP_ADD:  res = a + b;
            rvx_pkg::OP_SUB:  res = a - b;
            rvx_pkg::OP_AND:  res = a & b;
            rvx_pkg::OP_XOR:  res = a ^ b;
            rvx_pkg::OP_ADDI: res = a + imm;
            rvx_pkg::OP_LW:   res = model_mem[midx];
            rvx_pkg::OP_SW: begin
                model_mem[midx] = b;
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != '0) begin
            model_regs[rd] = res;
        end
    endtask

    // Starts at 2 ns after an edge and returns at the same point after completion,
    // so consecutive calls give back-to-back transfers
    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input rvx_pkg::word_t wdata,
                                output rvx_pkg::word_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        // Reads and writes to other addresses are ready in the first access cycle
        @(negedge clk);
        if (!wr || addr != `RVX_ADDR_INSTR) begin
            check_flag("pready in first access cycle", pready, 1'b1);
        end
        // Access phase stretches while the slave holds pready low
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input rvx_pkg::word_t data,
                             output logic err);
        rvx_pkg::word_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output rvx_pkg::word_t data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    // An idle cycle now and then spaces two words three cycles apart,
    // so the reader sits in ID while the writer is in WB
    task automatic issue(input rvx_pkg::word_t ins);
        logic err;
        if (next_rand_bit()) begin
            @(posedge clk);
            #2;
        end
        apb_write(`RVX_ADDR_INSTR, ins, err);
        check_flag("pslverr on push", err, 1'b0);
        model_exec(ins);
    endtask

    task automatic read_status(output logic busy_bit, output logic [3:0] cnt);
        rvx_pkg::word_t data;
        logic           err;
        apb_read(`RVX_ADDR_STATUS, data, err);
        check_flag("pslverr on status", err, 1'b0);
        busy_bit = data[0];
        cnt      = data[7:4];
    endtask

    // Busy covers both the FIFO and the pipe, the watchdog bounds the loop
    task automatic wait_idle();
        logic       busy_bit;
        logic [3:0] cnt;
        do begin
            read_status(busy_bit, cnt);
        end while (busy_bit);
    endtask

    task automatic check_all_regs();
        rvx_pkg::word_t data;
        logic           err;
        for (int i = 0; i < `RVX_NREG; i++) begin
            apb_read(`RVX_ADDR_REG_BASE + 12'(4 * i), data, err);
            check_flag("pslverr on register read", err, 1'b0);
            check_word($sformatf("r%0d", i), data, model_regs[i]);
        end
    endtask

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WDOG_CYC);
        stop_on_error();
    end

    // Concurrent assertions in the core end the run as soon as one fails
    initial begin
        wait (u_rvx_top.u_core.u_tb_assert.fail_count != 0);
        $display("A concurrent assertion in the core failed");
        stop_on_error();
    end

    initial begin
        rvx_pkg::word_t    rdata;
        rvx_pkg::reg_idx_t ld_rd;
        logic              err;
        logic              busy_bit;
        logic [3:0]        cnt;
        lfsr_state = 32'h1ab7_3ecf;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        for (int i = 0; i < `RVX_NREG; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `RVX_DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Idle and cleared after reset
        read_status(busy_bit, cnt);
        check_flag("status busy", busy_bit, 1'b0);
        check_count("status count", cnt, 4'd0);
        check_all_regs();

        // Dependent ALU chains over the small register pool
        for (int i = 0; i < N_ALU; i++) begin
            issue(make_instr(alu_op(), pool_reg(), pool_reg(), pool_reg(),
                             13'(rand_bits(13))));
        end
        wait_idle();
        check_all_regs();

        // Store, load, then a word that reads the loaded register right away
        for (int i = 0; i < N_LDUSE; i++) begin
            issue(make_instr(rvx_pkg::OP_SW, pool_reg(), pool_reg(), pool_reg(),
                             13'(rand_bits(13))));
            ld_rd = pool_reg();
            issue(make_instr(rvx_pkg::OP_LW, ld_rd, pool_reg(), pool_reg(),
                             13'(rand_bits(13))));
            issue(make_instr(alu_op(), pool_reg(), ld_rd, ld_rd, 13'(rand_bits(13))));
        end
        wait_idle();
        check_all_regs();

        // Burst of pushes with a status read in the middle of it
        for (int i = 0; i < N_BURST; i++) begin
            issue(make_instr(alu_op(), pool_reg(), pool_reg(), pool_reg(),
                             13'(rand_bits(13))));
            if (i == N_BURST / 2) begin
                read_status(busy_bit, cnt);
                // The word just pushed is still in the FIFO or in the pipe
                check_flag("status busy mid-burst", busy_bit, 1'b1);
                if (cnt > `RVX_FIFO_DEPTH) begin
                    $display("FIFO count %0d read mid-burst is above the FIFO depth", cnt);
                    stop_on_error();
                end
            end
        end
        wait_idle();
        check_all_regs();

        // Illegal accesses complete with an error and change nothing
        apb_write(`RVX_ADDR_STATUS, rand_bits(32), err);
        check_flag("pslverr on status write", err, 1'b1);
        apb_write(`RVX_ADDR_REG_BASE + 12'h014, rand_bits(32), err);
        check_flag("pslverr on register write", err, 1'b1);
        apb_read(12'h040, rdata, err);
        check_flag("pslverr on unmapped read", err, 1'b1);
        read_status(busy_bit, cnt);
        check_flag("status busy", busy_bit, 1'b0);
        check_count("status count", cnt, 4'd0);
        check_all_regs();

        // A write to r0 followed at once by a reader of r0
        for (int i = 0; i < N_R0 / 2; i++) begin
            issue(make_instr((i % 2 == 0) ? rvx_pkg::OP_ADDI : rvx_pkg::OP_LW, 5'd0,
                             pool_reg(), pool_reg(), 13'(rand_bits(13))));
            issue(make_instr(rvx_pkg::OP_ADD, 5'(rand_bits(3) % 7 + 1), 5'd0,
                             pool_reg(), 13'(rand_bits(13))));
        end
        wait_idle();
        check_all_regs();

        if (u_rvx_top.u_core.u_tb_assert.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("%0d assertion failures were reported",
                     u_rvx_top.u_core.u_tb_assert.fail_count);
            stop_on_error();
        end
    end

endmodule

/* src.f */
+incdir+hw
hw/rvx_pkg.sv
hw/rvx_apb_cmd.sv
hw/rvx_instr_fifo.sv
hw/rvx_regfile.sv
hw/rvx_forward.sv
hw/rvx_core.sv
hw/rvx_top.sv
dv/rvx_tb_assert.sv
dv/rvx_tb.sv
